// File: src/fll_pkg.sv
package fll_pkg;

  // basic widths
  typedef logic [31:0] fll_data_t;      // config/status word
  typedef logic [3:0]  fll_reg_addr_t;  // word index inside one FLL
  typedef logic [1:0]  fll_sel_t;       // FLL select, PADDR[7:6]

  // number of FLL config ports behind the bridge
  localparam int NUM_FLL = 3;

  // register map, word addresses inside one FLL
  localparam fll_reg_addr_t REG_STATUS = 4'd0;  // read only, bit 0 = lock
  localparam fll_reg_addr_t REG_MULT   = 4'd1;  // multiplier, write drops lock
  localparam fll_reg_addr_t REG_CFG1   = 4'd2;
  localparam fll_reg_addr_t REG_CFG2   = 4'd3;

  // bridge -> FLL request bundle
  // add and data are forced to zero while req is low
  typedef struct packed {
    logic          req;   // four-phase request level
    logic          wrn;   // high for read
    fll_reg_addr_t add;
    fll_data_t     data;
  } fll_req_t;

  // FLL -> bridge response bundle
  typedef struct packed {
    logic      ack;     // follows req one cycle later
    fll_data_t r_data;  // valid while ack is high
    logic      lock;    // not synchronous to HCLK on real silicon
  } fll_rsp_t;

  // bridge FSM
  typedef enum logic [2:0] {
    IDLE,   // waiting for an access phase
    READ,   // req up, waiting for synced ack
    WRITE,
    WAIT,   // PREADY given, hold req until PENABLE drops
    ERROR   // select 3, error response
  } bridge_state_t;

endpackage

// File: src/apb_fll_if.sv
module apb_fll_if #(
  parameter int APB_ADDR_WIDTH = 12
) (
  input  logic                      HCLK,
  input  logic                      HRESETn,
  input  logic [APB_ADDR_WIDTH-1:0] PADDR,
  input  fll_pkg::fll_data_t        PWDATA,
  input  logic                      PWRITE,
  input  logic                      PSEL,
  input  logic                      PENABLE,
  output fll_pkg::fll_data_t        PRDATA,
  output logic                      PREADY,
  output logic                      PSLVERR,
  output fll_pkg::fll_req_t         fll_req [fll_pkg::NUM_FLL],
  input  fll_pkg::fll_rsp_t         fll_rsp [fll_pkg::NUM_FLL],
  output logic [fll_pkg::NUM_FLL-1:0] fll_lock
);

  import fll_pkg::*;

  bridge_state_t state;

  logic [NUM_FLL-1:0] req_q;      // one-hot request level per port
  logic [NUM_FLL-1:0] ack_in;
  logic [NUM_FLL-1:0] lock_in;
  logic [NUM_FLL-1:0] ack_meta;
  logic [NUM_FLL-1:0] ack_sync;
  logic [NUM_FLL-1:0] lock_meta;
  logic [NUM_FLL-1:0] lock_sync;

  logic          pready_q;
  logic          pslverr_q;
  fll_data_t     prdata_q;
  fll_reg_addr_t add_q;
  fll_data_t     data_q;
  logic          wrn_q;
  fll_data_t     rsp_data;

  fll_sel_t sel;
  logic     sel_err;
  logic     start;
  logic     done;

  assign sel     = fll_sel_t'(PADDR[7:6]);
  assign sel_err = (sel > fll_sel_t'(NUM_FLL - 1));  // select 3 has no FLL behind it

  // a new transfer may only start once every ack of the last one is back low
  assign start = (state == IDLE) && PSEL && PENABLE && !(|ack_sync);
  assign done  = ((state == READ) || (state == WRITE)) && |(ack_sync & req_q);

  for (genvar i = 0; i < NUM_FLL; i++) begin : g_port
    assign fll_req[i] = '{
      req:  req_q[i],
      wrn:  req_q[i] & wrn_q,
      add:  req_q[i] ? add_q : '0,
      data: req_q[i] ? data_q : '0
    };
    assign ack_in[i]  = fll_rsp[i].ack;
    assign lock_in[i] = fll_rsp[i].lock;
  end

  // read data of whichever port is requested
  always_comb begin
    rsp_data = '0;
    for (int i = 0; i < NUM_FLL; i++) begin
      if (req_q[i]) begin
        rsp_data = rsp_data | fll_rsp[i].r_data;
      end
    end
  end

  // two-flop synchronizers, FLLs sit in their own clock domain
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ack_meta  <= '0;
      ack_sync  <= '0;
      lock_meta <= '0;
      lock_sync <= '0;
    end else begin
      ack_meta  <= ack_in;
      ack_sync  <= ack_meta;
      lock_meta <= lock_in;
      lock_sync <= lock_meta;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state     <= IDLE;
      req_q     <= '0;
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            if (sel_err) begin
              pready_q  <= 1'b1;  // complete at once
              pslverr_q <= 1'b1;
              state     <= ERROR;
            end else begin
              for (int i = 0; i < NUM_FLL; i++) begin
                req_q[i] <= (sel == fll_sel_t'(i));
              end
              state <= PWRITE ? WRITE : READ;
            end
          end
        end
        READ, WRITE: begin
          if (done) begin
            pready_q <= 1'b1;
            state    <= WAIT;
          end
        end
        WAIT: begin
          pready_q <= 1'b0;
          if (!PENABLE) begin
            req_q <= '0;  // release, ack falls in turn
            state <= IDLE;
          end
        end
        ERROR: begin
          pready_q  <= 1'b0;
          pslverr_q <= 1'b0;
          state     <= WAIT;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // transfer payload, captured at start of transfer
  always_ff @(posedge HCLK) begin
    if (start) begin
      add_q  <= PADDR[5:2];
      data_q <= PWDATA;
      wrn_q  <= ~PWRITE;
    end
    if (start && sel_err) begin
      prdata_q <= '0;
    end else if (done && (state == READ)) begin
      prdata_q <= rsp_data;  // r_data is stable while ack is high
    end
  end

  assign PREADY   = pready_q;
  assign PSLVERR  = pslverr_q;
  assign PRDATA   = prdata_q;
  assign fll_lock = lock_sync;

endmodule

// File: src/fll_cfg_regs.sv
module fll_cfg_regs #(
  parameter int LOCK_CYCLES = 16
) (
  input  logic              HCLK,
  input  logic              HRESETn,
  input  fll_pkg::fll_req_t fll_req,
  output fll_pkg::fll_rsp_t fll_rsp
);

  import fll_pkg::*;

  localparam int CNT_W = $clog2(LOCK_CYCLES + 1);

  typedef logic [CNT_W-1:0] lock_cnt_t;  // settling countdown

  logic      ack_q;
  fll_data_t r_data_q;
  fll_data_t mult_q;
  fll_data_t cfg1_q;
  fll_data_t cfg2_q;
  lock_cnt_t cnt_q;
  logic      lock;

  logic      new_req;
  logic      wr_en;
  logic      mult_wr;
  fll_data_t rd_word;

  // act only on the first cycle of a request
  assign new_req = fll_req.req && !ack_q;
  assign wr_en   = new_req && !fll_req.wrn;
  assign mult_wr = wr_en && (fll_req.add == REG_MULT);

  assign lock = (cnt_q == '0);

  always_comb begin
    case (fll_req.add)
      REG_STATUS: rd_word = {31'b0, lock};
      REG_MULT:   rd_word = mult_q;
      REG_CFG1:   rd_word = cfg1_q;
      REG_CFG2:   rd_word = cfg2_q;
      default:    rd_word = '0;  // unmapped words
    endcase
  end

  // ack follows req by one cycle, on both edges of the handshake
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ack_q <= 1'b0;
    end else if (new_req) begin
      ack_q <= 1'b1;
    end else if (!fll_req.req) begin
      ack_q <= 1'b0;
    end
  end

  // config words, status and unmapped writes are dropped
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      mult_q <= '0;
      cfg1_q <= '0;
      cfg2_q <= '0;
    end else if (wr_en) begin
      case (fll_req.add)
        REG_MULT: mult_q <= fll_req.data;
        REG_CFG1: cfg1_q <= fll_req.data;
        REG_CFG2: cfg2_q <= fll_req.data;
        default: ;
      endcase
    end
  end

  // lock emulator
  // a new multiplier restarts the settling time
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      cnt_q <= lock_cnt_t'(LOCK_CYCLES);
    end else if (mult_wr) begin
      cnt_q <= lock_cnt_t'(LOCK_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // read word sampled with the ack edge, held for the rest of the handshake
  always_ff @(posedge HCLK) begin
    if (new_req) begin
      r_data_q <= rd_word;
    end
  end

  assign fll_rsp = '{
    ack:    ack_q,
    r_data: r_data_q,
    lock:   lock
  };

endmodule

// File: src/fll_subsys_top.sv
module fll_subsys_top #(
  parameter int APB_ADDR_WIDTH = 12,
  parameter int LOCK_CYCLES    = 16
) (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic [APB_ADDR_WIDTH-1:0]   PADDR,
  input  fll_pkg::fll_data_t          PWDATA,
  input  logic                        PWRITE,
  input  logic                        PSEL,
  input  logic                        PENABLE,
  output fll_pkg::fll_data_t          PRDATA,
  output logic                        PREADY,
  output logic                        PSLVERR,
  output logic [fll_pkg::NUM_FLL-1:0] fll_lock
);

  import fll_pkg::*;

  fll_req_t fll_req [NUM_FLL];
  fll_rsp_t fll_rsp [NUM_FLL];

  // APB side, one config port per FLL
  apb_fll_if #(
    .APB_ADDR_WIDTH(APB_ADDR_WIDTH)
  ) u_bridge (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PWRITE  (PWRITE),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR),
    .fll_req (fll_req),
    .fll_rsp (fll_rsp),
    .fll_lock(fll_lock)
  );

  for (genvar i = 0; i < NUM_FLL; i++) begin : g_fll
    fll_cfg_regs #(
      .LOCK_CYCLES(LOCK_CYCLES)
    ) u_regs (
      .HCLK   (HCLK),
      .HRESETn(HRESETn),
      .fll_req(fll_req[i]),
      .fll_rsp(fll_rsp[i])
    );
  end

endmodule

// File: tests/fll_subsys_assert.sv
module fll_subsys_assert (
  input logic                   HCLK,
  input logic                   HRESETn,
  input logic                   PENABLE,
  input logic                   PREADY,
  input fll_pkg::fll_req_t      fll_req [fll_pkg::NUM_FLL]
);

  import fll_pkg::*;

  logic [NUM_FLL-1:0] req_vec;

  for (genvar i = 0; i < NUM_FLL; i++) begin : g_port
    assign req_vec[i] = fll_req[i].req;

    // req only drops once the master has closed the access phase
    a_req_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (fll_req[i].req && PENABLE) |=> fll_req[i].req)
      else $error("req of FLL port %0d dropped before PENABLE fell", i);

    a_idle_zero: assert property (@(posedge HCLK) disable iff (!HRESETn)
      !fll_req[i].req |-> (fll_req[i].add == '0) && (fll_req[i].data == '0))
      else $error("add or data of FLL port %0d not zero while req is low", i);
  end

  a_pready_reset: assert property (@(posedge HCLK) !HRESETn |=> !PREADY)
    else $error("PREADY high right after reset");

  a_one_req: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(req_vec))
    else $error("more than one FLL request active");  // decode is one-hot

endmodule

bind apb_fll_if fll_subsys_assert u_assert (
  .HCLK   (HCLK),
  .HRESETn(HRESETn),
  .PENABLE(PENABLE),
  .PREADY (PREADY),
  .fll_req(fll_req)
);

// File: tests/fll_subsys_tb.sv
module fll_subsys_tb;

  import fll_pkg::*;

  localparam int APB_ADDR_WIDTH = 12;
  localparam int LOCK_CYCLES    = 16;
  localparam int CYCLES_PER_VEC = 200;  // watchdog budget per stim line
  localparam int MAX_POLLS      = 20;

  // one line of the stim file
  typedef struct packed {
    logic [7:0]    op;    // W, R or P
    fll_sel_t      sel;
    fll_reg_addr_t addr;
    fll_data_t     data;  // write data or expected read data
    logic          err;   // expected PSLVERR
  } stim_vec_t;

  logic                      HCLK;
  logic                      HRESETn;
  logic [APB_ADDR_WIDTH-1:0] PADDR;
  fll_data_t                 PWDATA;
  logic                      PWRITE;
  logic                      PSEL;
  logic                      PENABLE;
  fll_data_t                 PRDATA;
  logic                      PREADY;
  logic                      PSLVERR;
  logic [NUM_FLL-1:0]        fll_lock;

  stim_vec_t vecs [$];
  int        vec_idx;
  logic      loaded;

  fll_subsys_top #(
    .APB_ADDR_WIDTH(APB_ADDR_WIDTH),
    .LOCK_CYCLES   (LOCK_CYCLES)
  ) dut0 (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PWRITE  (PWRITE),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR),
    .fll_lock(fll_lock)
  );

  always #10 HCLK = ~HCLK;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_data(input string name, input fll_data_t exp, input fll_data_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL t=%0t vector %0d %s expected %h actual %h",
                          $time, vec_idx, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL t=%0t vector %0d %s expected %b actual %b",
                          $time, vec_idx, name, exp, act));
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] sel;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] err;
    fd = $fopen("tests/fll_stim.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file tests/fll_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin  // skip comments and blanks
          n = $sscanf(line, "%s %h %h %h %h", op, sel, addr, data, err);
          if (n != 5) begin
            abort_run($sformatf("malformed stimulus line: %s", line));
          end
          vecs.push_back('{op, fll_sel_t'(sel), fll_reg_addr_t'(addr), data, err[0]});
        end
      end
      $fclose(fd);
    end
  endtask

  // one APB transfer, setup then access phase, held until PREADY
  task automatic apb_xfer(input logic write, input fll_sel_t sel, input fll_reg_addr_t addr,
                          input fll_data_t wdata, output fll_data_t rdata, output logic err);
    @(negedge HCLK);
    PADDR      = '0;
    PADDR[7:6] = sel;
    PADDR[5:2] = addr;
    PWDATA     = write ? wdata : '0;
    PWRITE     = write;
    PSEL       = 1'b1;
    PENABLE    = 1'b0;
    @(negedge HCLK);
    PENABLE = 1'b1;
    @(negedge HCLK);
    while (!PREADY) @(negedge HCLK);  // wait states, watchdog covers a hang
    rdata   = PRDATA;
    err     = PSLVERR;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  endtask

  // read status until it matches, lock settles over several reads
  task automatic poll_status(input fll_sel_t sel, input fll_data_t exp, input logic exp_err);
    fll_data_t rdata;
    logic      err;
    int        polls;
    polls = 0;
    rdata = ~exp;
    while (rdata !== exp && polls < MAX_POLLS) begin
      apb_xfer(1'b0, sel, REG_STATUS, '0, rdata, err);
      check_bit("PSLVERR", exp_err, err);
      polls++;
    end
    if (rdata !== exp) begin
      abort_run($sformatf("status of FLL %0d did not reach %h within %0d reads",
                          sel, exp, MAX_POLLS));
    end else if (sel < NUM_FLL) begin
      check_bit($sformatf("fll_lock[%0d]", sel), exp[0], fll_lock[sel]);
    end
  endtask

  task automatic run_vector(input stim_vec_t v);
    fll_data_t rdata;
    logic      err;
    case (v.op)
      "W": begin
        apb_xfer(1'b1, v.sel, v.addr, v.data, rdata, err);
        check_bit("PSLVERR", v.err, err);
      end
      "R": begin
        apb_xfer(1'b0, v.sel, v.addr, '0, rdata, err);
        check_bit("PSLVERR", v.err, err);
        check_data("PRDATA", v.data, rdata);
      end
      "P": poll_status(v.sel, v.data, v.err);
      default: abort_run($sformatf("unknown operation in stimulus vector %0d", vec_idx));
    endcase
  endtask

  // watchdog, budget follows the number of stim lines
  initial begin
    wait (loaded === 1'b1);
    repeat (vecs.size() * CYCLES_PER_VEC + 10) @(posedge HCLK);
    abort_run("watchdog expired before the stimulus finished");
  end

  initial begin
    HCLK    = 1'b0;
    HRESETn = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    PWRITE  = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    vec_idx = 0;
    loaded  = 1'b0;
    load_stim();
    loaded = 1'b1;
    repeat (3) @(negedge HCLK);  // reset held for 3 cycles
    HRESETn = 1'b1;
    for (int i = 0; i < vecs.size(); i++) begin
      vec_idx = i;
      run_vector(vecs[i]);
    end
    repeat (2) @(negedge HCLK);
    $display("Regression passed");
    $finish;
  end

endmodule

// File: tests/fll_stim.txt
# op sel addr data slverr, fields after op in hex
# W write, R read and compare, P read status until it equals data
R 0 2 00000000 0
R 0 3 00000000 0
R 1 1 00000000 0
R 2 3 00000000 0
P 0 0 00000001 0
P 1 0 00000001 0
P 2 0 00000001 0
W 0 2 a5a50001 0
W 0 3 5a5a0002 0
W 1 2 12340003 0
W 1 3 43210004 0
W 2 2 c0de0005 0
W 2 3 0badf006 0
R 0 2 a5a50001 0
R 0 3 5a5a0002 0
R 1 2 12340003 0
R 1 3 43210004 0
R 2 2 c0de0005 0
R 2 3 0badf006 0
W 1 1 00000040 0
R 1 0 00000000 0
R 0 1 00000000 0
P 1 0 00000001 0
R 1 1 00000040 0
W 3 2 ffffffff 1
R 3 2 00000000 1
R 0 2 a5a50001 0
R 1 2 12340003 0
R 2 2 c0de0005 0
R 0 4 00000000 0
R 1 9 00000000 0
W 2 f 0000ffff 0
R 2 f 00000000 0
W 2 0 00000000 0
R 2 0 00000001 0

// File: vlog.f
src/fll_pkg.sv
src/apb_fll_if.sv
src/fll_cfg_regs.sv
src/fll_subsys_top.sv
tests/fll_subsys_assert.sv
tests/fll_subsys_tb.sv

// File: Makefile
SIM := obj_dir/Vfll_subsys_tb

$(SIM): vlog.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module fll_subsys_tb -f vlog.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
